//--- src/uop_pkg.sv
package uop_pkg;

    // queue depth in micro-ops
    localparam int QUEUE_LEN     = 8;
    // lanes per fetch bundle
    localparam int DISPATCH_SIZE = 2;
    // micro-op count, 0 up to DISPATCH_SIZE
    localparam int CNT_W         = $clog2(DISPATCH_SIZE) + 1;
    // free slots and tail index, 0 up to QUEUE_LEN + 1
    localparam int SLOT_W        = $clog2(QUEUE_LEN) + 2;

    typedef logic [31:0] word_t;

    // supported rv32i major opcodes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    // execute-side alu selects
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_SLTU  = 4'd9,
        // operand b straight through, for lui
        ALU_PASSB = 4'd10
    } alu_op_t;

    // all-zero value is an invalid slot
    typedef struct packed {
        logic       valid;
        logic       illegal;
        word_t      pc;
        opcode_t    opcode;
        alu_op_t    alu_op;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        word_t      imm;
        logic       wen;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
    } uop_t;

endpackage

//--- src/rv_uop_decoder.sv
`timescale 1ns/10ps

module rv_uop_decoder import uop_pkg::*; (
    input  word_t instr,
    input  word_t pc,
    output uop_t  uop
);

    logic [2:0] funct3;
    logic       funct7_b5;
    logic [4:0] rd_f;
    logic [4:0] rs1_f;
    logic [4:0] rs2_f;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_t    alu_base;

    assign funct3    = instr[14:12];
    // sub and sra select, also bit 30 of the op-imm shifts
    assign funct7_b5 = instr[30];
    assign rd_f      = instr[11:7];
    assign rs1_f     = instr[19:15];
    assign rs2_f     = instr[24:20];

    // sign-extended immediates per format
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3 map shared by op and op-imm
    always_comb begin
        case (funct3)
            3'b000:  alu_base = ALU_ADD;
            3'b001:  alu_base = ALU_SLL;
            3'b010:  alu_base = ALU_SLT;
            3'b011:  alu_base = ALU_SLTU;
            3'b100:  alu_base = ALU_XOR;
            3'b101:  alu_base = funct7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  alu_base = ALU_OR;
            default: alu_base = ALU_AND;
        endcase
    end

    // unused source fields stay zero so they never match a load rd
    always_comb begin
        uop        = '0;
        uop.valid  = 1'b1;
        uop.pc     = pc;
        uop.opcode = opcode_t'(instr[6:0]);
        case (instr[6:0])
            OPC_OP: begin
                uop.alu_op = (funct3 == 3'b000 && funct7_b5) ? ALU_SUB : alu_base;
                uop.rd     = rd_f;
                uop.rs1    = rs1_f;
                uop.rs2    = rs2_f;
                uop.wen    = 1'b1;
            end
            OPC_OP_IMM: begin
                uop.alu_op = alu_base;
                uop.rd     = rd_f;
                uop.rs1    = rs1_f;
                uop.imm    = imm_i;
                uop.wen    = 1'b1;
            end
            OPC_LOAD: begin
                // address add
                uop.rd      = rd_f;
                uop.rs1     = rs1_f;
                uop.imm     = imm_i;
                uop.wen     = 1'b1;
                uop.is_load = 1'b1;
            end
            OPC_STORE: begin
                uop.rs1      = rs1_f;
                uop.rs2      = rs2_f;
                uop.imm      = imm_s;
                uop.is_store = 1'b1;
            end
            OPC_BRANCH: begin
                // beq/bne subtract, blt/bge signed, bltu/bgeu unsigned
                case (funct3[2:1])
                    2'b10:   uop.alu_op = ALU_SLT;
                    2'b11:   uop.alu_op = ALU_SLTU;
                    default: uop.alu_op = ALU_SUB;
                endcase
                uop.rs1       = rs1_f;
                uop.rs2       = rs2_f;
                uop.imm       = imm_b;
                uop.is_branch = 1'b1;
            end
            OPC_LUI: begin
                uop.alu_op = ALU_PASSB;
                uop.rd     = rd_f;
                uop.imm    = imm_u;
                uop.wen    = 1'b1;
            end
            OPC_JAL: begin
                uop.rd  = rd_f;
                uop.imm = imm_j;
                uop.wen = 1'b1;
            end
            default: begin
                // no write, no imm, still flows through the queue
                uop.illegal = 1'b1;
            end
        endcase
        // writes to x0 are dropped
        if (uop.rd == 5'd0) begin
            uop.wen = 1'b0;
        end
    end

endmodule

//--- src/decode_bundle.sv
`timescale 1ns/10ps

module decode_bundle import uop_pkg::*; (
    input  logic [DISPATCH_SIZE-1:0]  fetch_valid,
    input  word_t [DISPATCH_SIZE-1:0] fetch_instr,
    input  word_t                     fetch_pc,
    input  logic [SLOT_W-1:0]         num_free_slots,
    output uop_t [DISPATCH_SIZE-1:0]  ctrls,
    output logic [CNT_W-1:0]          num_uops,
    output logic                      store,
    output logic                      fetch_ready
);

    word_t [DISPATCH_SIZE-1:0] lane_pc;
    uop_t  [DISPATCH_SIZE-1:0] lane_uop;

    // one decoder per lane, lane n sits at pc + 4n
    for (genvar ln = 0; ln < DISPATCH_SIZE; ln++) begin : g_lane
        assign lane_pc[ln] = fetch_pc + word_t'(4 * ln);

        rv_uop_decoder i_rv_uop_decoder (
            .instr (fetch_instr[ln]),
            .pc    (lane_pc[ln]),
            .uop   (lane_uop[ln])
        );
    end

    // pack valid lanes down to index 0, count as we go
    always_comb begin
        ctrls    = '0;
        num_uops = '0;
        for (int i = 0; i < DISPATCH_SIZE; i++) begin
            if (fetch_valid[i]) begin
                ctrls[num_uops] = lane_uop[i];
                num_uops        = num_uops + 1'b1;
            end
        end
    end

    // whole bundle or nothing
    assign fetch_ready = {{(SLOT_W - CNT_W){1'b0}}, num_uops} <= num_free_slots;
    // empty bundles never store
    assign store       = fetch_ready && (|fetch_valid);

endmodule

//--- src/decode_queue.sv
`timescale 1ns/10ps

module decode_queue import uop_pkg::*; (
    input  logic                     CLK,
    input  logic                     nRST,
    input  uop_t [DISPATCH_SIZE-1:0] ctrls,
    input  logic                     store,
    input  logic                     stall_queue,
    input  logic                     flush_queue,
    input  logic [CNT_W-1:0]         num_uops,
    output logic [SLOT_W-1:0]        num_free_slots,
    output uop_t                     uop0
);

    // count of occupied slots, 0 is empty
    logic [SLOT_W-1:0] tail_idx;
    logic [SLOT_W-1:0] nxt_tail_idx;
    // occupancy left once this cycle's pop is done
    logic [SLOT_W-1:0] base_idx;
    // offset of a slot behind base_idx into ctrls
    int                slot_off;

    // slot 1 is the head, numbering from 1 keeps tail - 1 non-negative
    uop_t [QUEUE_LEN:1] queue_data;
    uop_t [QUEUE_LEN:1] nxt_queue_data;

    assign uop0 = queue_data[1];

    // head leaves unless stalled or nothing is there
    assign base_idx = (stall_queue || tail_idx == '0) ? tail_idx : tail_idx - 1'b1;

    // free count covers the departing head
    assign num_free_slots = SLOT_W'(QUEUE_LEN) - base_idx;

    always_comb begin
        nxt_queue_data = queue_data;
        slot_off       = 0;

        // pop, shift toward the head and pull in an empty slot
        if (!stall_queue) begin
            for (int i = 1; i < QUEUE_LEN; i++) begin
                nxt_queue_data[i] = queue_data[i + 1];
            end
            nxt_queue_data[QUEUE_LEN] = '0;
        end

        // append the new micro-ops right behind what remains
        if (store) begin
            for (int i = 1; i <= QUEUE_LEN; i++) begin
                slot_off = i - int'(base_idx) - 1;
                if (slot_off >= 0 && slot_off < int'(num_uops)) begin
                    nxt_queue_data[i] = ctrls[slot_off];
                end
            end
        end

        // flush wins over pop and store
        if (flush_queue) begin
            nxt_queue_data = '0;
        end
    end

    always_comb begin
        if (flush_queue) begin
            nxt_tail_idx = '0;
        end else if (store) begin
            nxt_tail_idx = base_idx + {{(SLOT_W - CNT_W){1'b0}}, num_uops};
        end else begin
            nxt_tail_idx = base_idx;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            tail_idx <= '0;
        end else begin
            tail_idx <= nxt_tail_idx;
        end
    end

    // entries start as invalid micro-ops
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            queue_data <= '0;
        end else begin
            queue_data <= nxt_queue_data;
        end
    end

endmodule

//--- src/issue_gate.sv
`timescale 1ns/10ps

module issue_gate import uop_pkg::*; (
    input  logic CLK,
    input  logic nRST,
    input  uop_t uop0,
    input  logic ex_busy,
    input  logic flush,
    output logic stall_queue,
    output logic issue_valid,
    output uop_t issue_uop
);

    // rd of the load issued last cycle, zero when none
    logic [4:0] load_rd;
    logic [4:0] nxt_load_rd;
    logic       hazard;

    // head reads what the load has not returned yet
    assign hazard = (load_rd != 5'd0) &&
                    ((uop0.rs1 == load_rd) || (uop0.rs2 == load_rd));

    // an empty head never stalls
    assign stall_queue = uop0.valid && (ex_busy || hazard);
    assign issue_valid = uop0.valid && !stall_queue;
    assign issue_uop   = uop0;

    // held for one cycle only, so the hazard stall is one cycle
    always_comb begin
        if (flush) begin
            nxt_load_rd = '0;
        end else if (issue_valid && uop0.is_load && uop0.wen) begin
            nxt_load_rd = uop0.rd;
        end else begin
            nxt_load_rd = '0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            load_rd <= '0;
        end else begin
            load_rd <= nxt_load_rd;
        end
    end

endmodule

//--- src/decode_front_top.sv
`timescale 1ns/10ps

module decode_front_top import uop_pkg::*; (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic [DISPATCH_SIZE-1:0]  fetch_valid,
    input  word_t [DISPATCH_SIZE-1:0] fetch_instr,
    input  word_t                     fetch_pc,
    input  logic                      flush,
    input  logic                      ex_busy,
    output logic                      fetch_ready,
    output logic                      issue_valid,
    output uop_t                      issue_uop
);

    // bundle to queue
    uop_t [DISPATCH_SIZE-1:0] ctrls;
    logic [CNT_W-1:0]         num_uops;
    logic                     store;
    logic [SLOT_W-1:0]        num_free_slots;
    // queue to issue gate and back
    uop_t                     uop0;
    logic                     stall_queue;

    decode_bundle i_decode_bundle (
        .fetch_valid    (fetch_valid),
        .fetch_instr    (fetch_instr),
        .fetch_pc       (fetch_pc),
        .num_free_slots (num_free_slots),
        .ctrls          (ctrls),
        .num_uops       (num_uops),
        .store          (store),
        .fetch_ready    (fetch_ready)
    );

    decode_queue i_decode_queue (
        .CLK            (CLK),
        .nRST           (nRST),
        .ctrls          (ctrls),
        .store          (store),
        .stall_queue    (stall_queue),
        .flush_queue    (flush),
        .num_uops       (num_uops),
        .num_free_slots (num_free_slots),
        .uop0           (uop0)
    );

    issue_gate i_issue_gate (
        .CLK         (CLK),
        .nRST        (nRST),
        .uop0        (uop0),
        .ex_busy     (ex_busy),
        .flush       (flush),
        .stall_queue (stall_queue),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop)
    );

endmodule

//--- dv/decode_front_properties.sv
`timescale 1ns/10ps

module decode_front_properties import uop_pkg::*; (
    input logic              CLK,
    input logic              nRST,
    input logic [SLOT_W-1:0] tail_idx,
    input logic [SLOT_W-1:0] num_free_slots,
    input logic              flush_queue,
    input uop_t              uop0
);

    // failed assertions so far
    int assert_fails = 0;

    // departing head counts as free, so depth plus one at most
    free_slots_bounded: assert property (@(posedge CLK) disable iff (!nRST)
        num_free_slots <= SLOT_W'(QUEUE_LEN + 1))
    else begin
        assert_fails++;
        $error("free slot count %0d above queue depth plus one", num_free_slots);
    end

    // occupancy never runs past the last entry
    tail_in_range: assert property (@(posedge CLK) disable iff (!nRST)
        tail_idx <= SLOT_W'(QUEUE_LEN))
    else begin
        assert_fails++;
        $error("tail index %0d past the last queue entry", tail_idx);
    end

    // flush empties the head at the next edge
    flush_clears_head: assert property (@(posedge CLK) disable iff (!nRST)
        flush_queue |=> !uop0.valid)
    else begin
        assert_fails++;
        $error("head still valid one cycle after flush");
    end

endmodule

//--- dv/decode_front_tasks.svh
`ifndef DECODE_FRONT_TASKS_SVH
`define DECODE_FRONT_TASKS_SVH

// random word with the major opcode forced
function automatic word_t rand_instr(logic [6:0] opc);
    word_t w;
    w = $random(seed);
    return {w[31:7], opc};
endfunction

// nonzero register number
function automatic logic [4:0] rand_reg();
    logic [4:0] r;
    r = 5'($random(seed));
    return (r == 5'd0) ? 5'd1 : r;
endfunction

// lw rd, 16(rs1)
function automatic word_t enc_load(logic [4:0] rd, logic [4:0] rs1);
    return {12'h010, rs1, 3'b010, rd, 7'b0000011};
endfunction

// add rd, rs1, rs2
function automatic word_t enc_add(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
endfunction

// expected micro-op straight from the rv32i field rules
function automatic uop_t ref_decode(word_t instr, word_t pc);
    alu_op_t    f3_map [8];
    logic [6:0] opc;
    logic [2:0] f3;
    logic       has_rd;
    logic       has_rs1;
    logic       has_rs2;
    uop_t       u;
    f3_map  = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    opc     = instr[6:0];
    f3      = instr[14:12];
    has_rd  = opc inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_LUI, OPC_JAL};
    has_rs1 = opc inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH};
    has_rs2 = opc inside {OPC_OP, OPC_STORE, OPC_BRANCH};
    u           = '0;
    u.valid     = 1'b1;
    u.pc        = pc;
    u.opcode    = opcode_t'(opc);
    u.illegal   = !(has_rs1 || has_rd);
    u.rd        = has_rd ? instr[11:7] : 5'd0;
    u.rs1       = has_rs1 ? instr[19:15] : 5'd0;
    u.rs2       = has_rs2 ? instr[24:20] : 5'd0;
    // x0 destination means no write
    u.wen       = has_rd && (instr[11:7] != 5'd0);
    u.is_load   = (opc == OPC_LOAD);
    u.is_store  = (opc == OPC_STORE);
    u.is_branch = (opc == OPC_BRANCH);
    case (opc)
        OPC_OP, OPC_OP_IMM: begin
            u.alu_op = f3_map[f3];
            if (f3 == 3'b101 && instr[30]) begin
                u.alu_op = ALU_SRA;
            end
            // sub only exists in the register form
            if (opc == OPC_OP && f3 == 3'b000 && instr[30]) begin
                u.alu_op = ALU_SUB;
            end
            if (opc == OPC_OP_IMM) begin
                u.imm = 32'($signed(instr[31:20]));
            end
        end
        OPC_LOAD: u.imm = 32'($signed(instr[31:20]));
        OPC_STORE: u.imm = 32'($signed({instr[31:25], instr[11:7]}));
        OPC_BRANCH: begin
            // beq/bne compare by subtract, blt/bge signed, bltu/bgeu unsigned
            u.alu_op = !f3[2] ? ALU_SUB : (f3[1] ? ALU_SLTU : ALU_SLT);
            u.imm    = 32'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
        end
        OPC_LUI: begin
            u.alu_op = ALU_PASSB;
            u.imm    = {instr[31:12], 12'h000};
        end
        OPC_JAL: u.imm = 32'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));
        default: u.imm = '0;
    endcase
    return u;
endfunction

task automatic compare_uop(string name, uop_t got, uop_t exp);
    checks++;
    if (got !== exp) begin
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic compare_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        errors++;
    end
endtask

// distance between the last two issues
task automatic check_issue_gap(string what, int exp_gap);
    int n;
    int gap;
    n = issue_cyc.size();
    checks++;
    if (n < 2) begin
        $display("%s: fewer than two micro-ops issued", what);
        errors++;
    end else begin
        gap = issue_cyc[n-1] - issue_cyc[n-2];
        if (gap != exp_gap) begin
            $display("%s: issued %0d cycles apart instead of %0d", what, gap, exp_gap);
            errors++;
        end
    end
endtask

// put a bundle on the fetch port, pc advances by one bundle
task automatic present_bundle(logic [1:0] vld, word_t i0, word_t i1);
    @(posedge CLK);
    fetch_valid <= vld;
    fetch_instr <= {i1, i0};
    fetch_pc    <= pc_base;
    pc_base = pc_base + 32'd8;
endtask

// held until fetch_ready, taken on the following edge
task automatic send_bundle(logic [1:0] vld, word_t i0, word_t i1);
    present_bundle(vld, i0, i1);
    do @(negedge CLK); while (!fetch_ready);
endtask

task automatic drive_idle();
    @(posedge CLK);
    fetch_valid <= '0;
endtask

task automatic wait_drain();
    do @(posedge CLK); while (exp_q.size() != 0);
endtask

task automatic single_addi();
    word_t instr;
    word_t pc;
    instr        = rand_instr(OPC_OP_IMM);
    instr[14:12] = 3'b000;
    pc           = pc_base;
    send_bundle(2'b01, instr, '0);
    drive_idle();
    // one cycle after acceptance
    @(negedge CLK);
    compare_bit("issue_valid", issue_valid, 1'b1);
    compare_uop("issue_uop", issue_uop, ref_decode(instr, pc));
    wait_drain();
endtask

task automatic mixed_bundles();
    send_bundle(2'b11, rand_instr(OPC_OP), rand_instr(OPC_STORE));
    // lane 1 alone, compacts to slot 0 with pc + 4
    send_bundle(2'b10, rand_instr(OPC_LOAD), rand_instr(OPC_BRANCH));
    send_bundle(2'b11, rand_instr(OPC_LUI), rand_instr(OPC_JAL));
    send_bundle(2'b10, rand_instr(OPC_OP_IMM), rand_instr(OPC_OP));
    send_bundle(2'b11, rand_instr(OPC_LOAD), rand_instr(OPC_OP_IMM));
    drive_idle();
    wait_drain();
endtask

task automatic busy_fill();
    @(posedge CLK);
    ex_busy <= 1'b1;
    for (int b = 0; b < 3; b++) begin
        send_bundle(2'b11, rand_instr(OPC_OP), rand_instr(OPC_LOAD));
    end
    send_bundle(2'b10, rand_instr(OPC_STORE), rand_instr(OPC_LUI));
    // seven held, one free slot against two lanes
    present_bundle(2'b11, rand_instr(OPC_BRANCH), rand_instr(OPC_JAL));
    @(negedge CLK);
    compare_bit("fetch_ready", fetch_ready, 1'b0);
    @(posedge CLK);
    ex_busy <= 1'b0;
    do @(negedge CLK); while (!fetch_ready);
    drive_idle();
    wait_drain();
endtask

task automatic load_use_spacing();
    logic [4:0] ld;
    ld = rand_reg();
    // consumer reads the load rd, one stall cycle
    send_bundle(2'b11, enc_load(ld, rand_reg()), enc_add(rand_reg(), ld, ld + 5'd1));
    drive_idle();
    wait_drain();
    check_issue_gap("dependent load pair", 2);
    ld = rand_reg();
    send_bundle(2'b11, enc_load(ld, rand_reg()), enc_add(ld, ld + 5'd1, ld + 5'd2));
    drive_idle();
    wait_drain();
    check_issue_gap("independent load pair", 1);
    // load to x0, consumer reads x0
    send_bundle(2'b11, enc_load(5'd0, rand_reg()), enc_add(rand_reg(), 5'd0, 5'd0));
    drive_idle();
    wait_drain();
    check_issue_gap("x0 load pair", 1);
endtask

task automatic flush_partial();
    @(posedge CLK);
    ex_busy <= 1'b1;
    send_bundle(2'b11, rand_instr(OPC_OP_IMM), rand_instr(OPC_STORE));
    send_bundle(2'b01, rand_instr(OPC_BRANCH), rand_instr(OPC_LUI));
    // bundle offered in the flush cycle is dropped
    present_bundle(2'b11, rand_instr(OPC_LOAD), rand_instr(OPC_OP));
    flush <= 1'b1;
    @(posedge CLK);
    fetch_valid <= '0;
    flush       <= 1'b0;
    ex_busy     <= 1'b0;
    // quiet window, nothing left to issue
    repeat (4) begin
        @(negedge CLK);
        compare_bit("issue_valid", issue_valid, 1'b0);
    end
    send_bundle(2'b11, rand_instr(OPC_OP), rand_instr(OPC_JAL));
    drive_idle();
    wait_drain();
endtask

task automatic illegal_opcode();
    word_t sys_word;
    word_t fence_word;
    sys_word   = rand_instr(7'b1110011);
    fence_word = rand_instr(7'b0001111);
    send_bundle(2'b11, sys_word, rand_instr(OPC_OP_IMM));
    send_bundle(2'b11, rand_instr(OPC_LUI), fence_word);
    send_bundle(2'b10, rand_instr(OPC_OP), sys_word);
    drive_idle();
    wait_drain();
endtask

`endif

//--- dv/decode_front_tb.sv
`timescale 1ns/10ps

module decode_front_tb import uop_pkg::*; ();

    logic                      CLK;
    logic                      nRST;
    logic [DISPATCH_SIZE-1:0]  fetch_valid;
    word_t [DISPATCH_SIZE-1:0] fetch_instr;
    word_t                     fetch_pc;
    logic                      flush;
    logic                      ex_busy;
    logic                      fetch_ready;
    logic                      issue_valid;
    uop_t                      issue_uop;

    integer seed        = 45852;
    int     errors      = 0;
    int     checks      = 0;
    // roughly four times the summed length of all tests
    int     cycle_limit = 2000;
    int     cycles      = 0;
    // lane 0 pc of the next bundle
    word_t  pc_base     = 32'h0000_1000;
    // expected micro-ops, acceptance order, lane 0 first
    uop_t   exp_q[$];
    // cycle number of each issue_valid
    int     issue_cyc[$];

    `include "decode_front_tasks.svh"

    decode_front_top i_decode_front_top (
        .CLK         (CLK),
        .nRST        (nRST),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .fetch_pc    (fetch_pc),
        .flush       (flush),
        .ex_busy     (ex_busy),
        .fetch_ready (fetch_ready),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop)
    );

    bind decode_queue decode_front_properties i_decode_front_properties (
        .CLK            (CLK),
        .nRST           (nRST),
        .tail_idx       (tail_idx),
        .num_free_slots (num_free_slots),
        .flush_queue    (flush_queue),
        .uop0           (uop0)
    );

    // 4 ns period
    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", cycle_limit);
        $display("Regression failed");
        $finish;
    end

    // mid-cycle sampling, inputs only move on the rising edge
    always @(negedge CLK) begin
        if (nRST) begin
            if (issue_valid) begin
                issue_cyc.push_back(cycles);
                if (exp_q.size() == 0) begin
                    $display("issue_valid with nothing accepted, pc %h", issue_uop.pc);
                    errors++;
                end else begin
                    compare_uop("issue_uop", issue_uop, exp_q.pop_front());
                end
            end
            // busy head holds, so free slots track the model depth
            if (ex_busy) begin
                compare_bit("fetch_ready", fetch_ready,
                            $countones(fetch_valid) <= QUEUE_LEN - exp_q.size());
            end
            // flush drops everything, including this cycle's bundle
            if (flush) begin
                exp_q.delete();
            end else if (fetch_ready && |fetch_valid) begin
                for (int ln = 0; ln < DISPATCH_SIZE; ln++) begin
                    if (fetch_valid[ln]) begin
                        exp_q.push_back(ref_decode(fetch_instr[ln],
                                                   fetch_pc + word_t'(4 * ln)));
                    end
                end
            end
        end
    end

    initial begin
        nRST        = 1'b0;
        fetch_valid = '0;
        fetch_instr = '0;
        fetch_pc    = '0;
        flush       = 1'b0;
        ex_busy     = 1'b0;
        repeat (4) @(posedge CLK);
        nRST <= 1'b1;
        // empty queue out of reset
        @(negedge CLK);
        compare_bit("fetch_ready", fetch_ready, 1'b1);
        compare_bit("issue_valid", issue_valid, 1'b0);
        single_addi();
        mixed_bundles();
        busy_fill();
        load_use_spacing();
        flush_partial();
        illegal_opcode();
        if (exp_q.size() != 0) begin
            $display("%0d accepted micro-ops never issued", exp_q.size());
            errors++;
        end
        errors += i_decode_front_top.i_decode_queue.i_decode_front_properties.assert_fails;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+dv
src/uop_pkg.sv
src/rv_uop_decoder.sv
src/decode_bundle.sv
src/decode_queue.sv
src/issue_gate.sv
src/decode_front_top.sv
dv/decode_front_properties.sv
dv/decode_front_tb.sv
